// File: rtl/tlp_pkg.sv
package tlp_pkg;

  // Avalon-ST stream geometry
  localparam int ST_DATA_W    = 256;
  localparam int DW_PER_BEAT  = 8;  // 32-bit dwords per beat
  localparam int EMPTY_W      = 3;

  // TLP header field widths
  localparam int REQ_ID_W     = 16;
  localparam int TAG_W        = 8;
  localparam int LEN_W        = 10;
  localparam int BYTE_COUNT_W = 12;
  localparam int ADDR_W       = 32;  // 3DW headers only

  // 512 KiB BAR window
  localparam logic [ADDR_W-1:0] BAR_ADDR_MASK = 32'h0007_FFFF;

  // Completion header codes
  localparam logic [2:0] CPL_FMT_NO_DATA = 3'b000;
  localparam logic [2:0] CPL_FMT_DATA    = 3'b010;
  localparam logic [4:0] CPL_TYPE        = 5'b01010;
  localparam logic [2:0] CPL_STATUS_OK   = 3'b000;
  localparam logic [2:0] CPL_STATUS_UR   = 3'b001;

  // cpl_err bit positions
  localparam int CPL_ERR_UR_P_BIT  = 4;  // Posted UR
  localparam int CPL_ERR_UR_NP_BIT = 5;  // Non-posted UR

  // Memory access request/response
  localparam int MEM_MSG_W        = 128;
  localparam int MEM_REQ_ADDR_LSB = 33;  // Where address bit 2 lands

  typedef enum logic [2:0] {
    MRD,
    MRDLK,
    MWR,
    CPL,
    CPLD,
    UNKNOWN
  } tlp_kind_t;

  // CSR map
  localparam int CSR_ADDR_W = 6;
  localparam logic [CSR_ADDR_W-1:0] CSR_MY_ID        = 6'd0;
  localparam logic [CSR_ADDR_W-1:0] CSR_RX_COUNT     = 6'd1;
  localparam logic [CSR_ADDR_W-1:0] CSR_UR_COUNT     = 6'd2;
  localparam logic [CSR_ADDR_W-1:0] CSR_CPLD_COUNT   = 6'd3;
  localparam logic [CSR_ADDR_W-1:0] CSR_MEMREQ_COUNT = 6'd4;
  localparam logic [31:0]           CSR_BAD_DATA     = 32'hFFFF_FFFF;

endpackage

// File: rtl/rx_frame_if.sv
`timescale 1ns/1ns

// One decoded receive TLP, decoder to dispatcher
interface rx_frame_if;
  tlp_pkg::tlp_kind_t                  kind;
  logic [tlp_pkg::TAG_W-1:0]           tag;
  logic [tlp_pkg::REQ_ID_W-1:0]        requester_id;
  logic [tlp_pkg::ADDR_W-1:0]          address;       // Unmasked
  logic [31:0]                         data;          // First payload dword
  logic [tlp_pkg::BYTE_COUNT_W-1:0]    byte_count;
  logic                                is_npr;        // Needs a completion
  logic                                is_pr;
  logic                                unsupported;
  logic                                is_start;      // Strobes
  logic                                is_end;

  modport producer (
    output kind, tag, requester_id, address, data, byte_count,
    output is_npr, is_pr, unsupported, is_start, is_end
  );

  modport consumer (
    input kind, tag, requester_id, address, data, byte_count,
    input is_npr, is_pr, unsupported, is_start, is_end
  );
endinterface

// File: rtl/tlp_rx_decoder.sv
`timescale 1ns/1ns

module tlp_rx_decoder (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          my_id_valid,
  input  logic [tlp_pkg::ST_DATA_W-1:0] rx_data,
  input  logic                          rx_sop,
  input  logic                          rx_eop,
  input  logic                          rx_valid,
  output logic                          rx_ready,
  rx_frame_if.producer                  frame,
  output logic                          rx_event
);

  logic [tlp_pkg::DW_PER_BEAT-1:0][31:0] dw;
  logic [2:0]                            fmt;
  logic [4:0]                            raw_type;
  logic [tlp_pkg::LEN_W-1:0]             len;
  logic                                  accept;
  tlp_pkg::tlp_kind_t                    kind_in;
  logic [tlp_pkg::BYTE_COUNT_W-1:0]      len_bytes;
  logic [tlp_pkg::BYTE_COUNT_W-1:0]      bc_in;
  logic [tlp_pkg::LEN_W-1:0]             len_q;     // Held with the frame
  logic                                  is_4dw_q;

  assign dw       = rx_data;
  assign fmt      = dw[0][31:29];
  assign raw_type = dw[0][28:24];
  assign len      = dw[0][tlp_pkg::LEN_W-1:0];
  assign len_bytes = {len, 2'b00};

  assign rx_ready = my_id_valid;  // No back-pressure beyond the ID
  assign accept   = my_id_valid & rx_valid;
  assign rx_event = frame.is_start;  // One per accepted TLP

  always_comb begin
    case ({fmt[1], raw_type})
      6'b000000: kind_in = tlp_pkg::MRD;
      6'b000001: kind_in = tlp_pkg::MRDLK;
      6'b100000: kind_in = tlp_pkg::MWR;
      6'b001010: kind_in = tlp_pkg::CPL;
      6'b101010: kind_in = tlp_pkg::CPLD;
      default:   kind_in = tlp_pkg::UNKNOWN;
    endcase
  end

  // Byte count from length and {first BE, last BE}, per the PCIe spec table
  always_comb begin
    casez ({dw[1][3:0], dw[1][7:4]})
      8'b1??10000: bc_in = 12'd4;
      8'b01?10000: bc_in = 12'd3;
      8'b1?100000: bc_in = 12'd3;
      8'b00110000: bc_in = 12'd2;
      8'b01100000: bc_in = 12'd2;
      8'b11000000: bc_in = 12'd2;
      8'b00010000: bc_in = 12'd1;
      8'b00100000: bc_in = 12'd1;
      8'b01000000: bc_in = 12'd1;
      8'b10000000: bc_in = 12'd1;
      8'b00000000: bc_in = 12'd1;  // Zero-length request
      8'b???11???: bc_in = len_bytes;
      8'b???101??: bc_in = len_bytes - 12'd1;
      8'b???1001?: bc_in = len_bytes - 12'd2;
      8'b???10001: bc_in = len_bytes - 12'd3;
      8'b??101???: bc_in = len_bytes - 12'd1;
      8'b??1001??: bc_in = len_bytes - 12'd2;
      8'b??10001?: bc_in = len_bytes - 12'd3;
      8'b??100001: bc_in = len_bytes - 12'd4;
      8'b?1001???: bc_in = len_bytes - 12'd2;
      8'b?10001??: bc_in = len_bytes - 12'd3;
      8'b?100001?: bc_in = len_bytes - 12'd4;
      8'b?1000001: bc_in = len_bytes - 12'd5;
      8'b10001???: bc_in = len_bytes - 12'd3;
      8'b100001??: bc_in = len_bytes - 12'd4;
      8'b1000001?: bc_in = len_bytes - 12'd5;
      8'b10000001: bc_in = len_bytes - 12'd6;
      default:     bc_in = '0;  // Invalid BE combination
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      frame.is_start <= 1'b0;
      frame.is_end   <= 1'b0;
    end else begin
      frame.is_start <= accept & rx_sop;
      frame.is_end   <= accept & rx_eop;
    end
  end

  // Header capture on start of packet
  always_ff @(posedge clk) begin
    if (accept && rx_sop) begin
      frame.kind       <= kind_in;
      len_q            <= len;
      is_4dw_q         <= fmt[0];
      frame.byte_count <= bc_in;
      if (kind_in == tlp_pkg::CPL || kind_in == tlp_pkg::CPLD) begin
        frame.requester_id <= dw[2][31:16];
        frame.tag          <= dw[2][15:8];
      end else begin
        frame.requester_id <= dw[1][31:16];
        frame.tag          <= dw[1][15:8];
      end
      // 4DW keeps the low address dword so the UR lower address stays right
      frame.address <= fmt[0] ? {dw[3][31:2], 2'b00} : {dw[2][31:2], 2'b00};
      frame.data    <= fmt[0] ? dw[4] : dw[3];
      frame.is_npr  <= 1'b0;
      frame.is_pr   <= 1'b0;
      casez ({fmt[1], raw_type})
        6'b00000?: frame.is_npr <= 1'b1;  // MRd, MRdLk
        6'b?00010: frame.is_npr <= 1'b1;  // IORd, IOWr
        6'b1011??: frame.is_npr <= 1'b1;  // AtomicOp
        6'b100000: frame.is_pr  <= 1'b1;  // MWr
        6'b?10???: frame.is_pr  <= 1'b1;  // Msg, MsgD
        default: ;
      endcase
    end
  end

  always_comb begin
    frame.unsupported = 1'b0;
    case (frame.kind)
      tlp_pkg::UNKNOWN, tlp_pkg::CPL, tlp_pkg::MRDLK: frame.unsupported = 1'b1;
      tlp_pkg::MRD, tlp_pkg::MWR: begin
        if (len_q != 10'd1)
          frame.unsupported = 1'b1;  // Single dword only
        else if (frame.byte_count != 12'd0 && frame.byte_count != 12'd4)
          frame.unsupported = 1'b1;
      end
      default: ;
    endcase
    if (is_4dw_q)
      frame.unsupported = 1'b1;  // No 64-bit addressing
  end

endmodule

// File: rtl/tlp_rx_dispatch.sv
`timescale 1ns/1ns

module tlp_rx_dispatch (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [tlp_pkg::REQ_ID_W-1:0]     my_id,
  rx_frame_if.consumer                     frame,
  output logic [tlp_pkg::MEM_MSG_W-1:0]    mem_req_data,
  output logic                             mem_req_valid,
  output logic [tlp_pkg::ST_DATA_W-1:0]    ur_data,
  output logic                             ur_valid,
  output logic                             ur_sop,
  output logic                             ur_eop,
  output logic [tlp_pkg::EMPTY_W-1:0]      ur_empty,
  output logic [6:0]                       cpl_err,
  output logic                             ur_event,
  output logic                             memreq_event
);

  logic [tlp_pkg::ADDR_W-1:0]            masked_addr;
  logic                                  is_mem;
  logic                                  is_wr;
  logic                                  mem_fire;
  logic                                  ur_fire;
  logic [tlp_pkg::MEM_MSG_W-1:0]         req_next;
  logic [tlp_pkg::DW_PER_BEAT-1:0][31:0] ur_dw;

  assign masked_addr = frame.address & tlp_pkg::BAR_ADDR_MASK;
  assign is_wr    = frame.kind == tlp_pkg::MWR;
  assign is_mem   = frame.kind == tlp_pkg::MRD || is_wr;  // Never for CplD
  assign mem_fire = frame.is_end & is_mem & ~frame.unsupported;
  assign ur_fire  = frame.is_end & frame.is_npr & frame.unsupported;

  always_comb begin
    req_next    = '0;
    req_next[0] = is_wr;
    if (is_wr)
      req_next[32:1] = frame.data;
    else
      req_next[32:1] = {8'b0, frame.tag, frame.requester_id};
    req_next[tlp_pkg::MEM_REQ_ADDR_LSB +: tlp_pkg::ADDR_W-2] = masked_addr[tlp_pkg::ADDR_W-1:2];
  end

  // UR completion header, no payload
  always_comb begin
    ur_dw            = '0;
    ur_dw[0][31:29]  = tlp_pkg::CPL_FMT_NO_DATA;
    ur_dw[0][28:24]  = tlp_pkg::CPL_TYPE;  // Length stays 0
    ur_dw[1][31:16]  = my_id;
    ur_dw[1][15:13]  = tlp_pkg::CPL_STATUS_UR;
    ur_dw[1][11:0]   = frame.byte_count;
    ur_dw[2][31:16]  = frame.requester_id;
    ur_dw[2][15:8]   = frame.tag;
    ur_dw[2][6:0]    = frame.address[6:0];  // Lower address
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_req_valid <= 1'b0;
      ur_valid      <= 1'b0;
      ur_sop        <= 1'b0;
      ur_eop        <= 1'b0;
    end else begin
      mem_req_valid <= mem_fire;
      ur_valid      <= ur_fire;
      ur_sop        <= ur_fire;  // Single beat
      ur_eop        <= ur_fire;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_fire)
      mem_req_data <= req_next;
    if (ur_fire) begin
      ur_data  <= ur_dw;
      ur_empty <= 3'd5;  // Three header dwords used
    end
  end

  always_comb begin
    cpl_err = '0;
    cpl_err[tlp_pkg::CPL_ERR_UR_NP_BIT] = frame.is_start & frame.unsupported & frame.is_npr;
    cpl_err[tlp_pkg::CPL_ERR_UR_P_BIT]  = frame.is_start & frame.unsupported & frame.is_pr;
  end

  assign ur_event     = ur_valid;
  assign memreq_event = mem_req_valid;

endmodule

// File: rtl/cpl_response_builder.sv
`timescale 1ns/1ns

module cpl_response_builder (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [tlp_pkg::REQ_ID_W-1:0]  my_id,
  input  logic                          my_id_valid,
  input  logic [tlp_pkg::MEM_MSG_W-1:0] mem_resp_data,
  input  logic                          mem_resp_valid,
  output logic                          mem_resp_ready,
  output logic [tlp_pkg::ST_DATA_W-1:0] cpl_data,
  output logic                          cpl_valid,
  output logic                          cpl_sop,
  output logic                          cpl_eop,
  output logic [tlp_pkg::EMPTY_W-1:0]   cpl_empty,
  output logic                          cpld_event
);

  logic [tlp_pkg::REQ_ID_W-1:0]          resp_req_id;
  logic [tlp_pkg::TAG_W-1:0]             resp_tag;
  logic [6:0]                            resp_lower_addr;
  logic [31:0]                           resp_rddata;
  logic                                  fire;
  logic [tlp_pkg::DW_PER_BEAT-1:0][31:0] cpl_dw;

  assign resp_req_id     = mem_resp_data[15:0];
  assign resp_tag        = mem_resp_data[23:16];
  assign resp_lower_addr = {mem_resp_data[28:24], 2'b00};
  assign resp_rddata     = mem_resp_data[63:32];

  assign mem_resp_ready = my_id_valid;
  assign fire           = my_id_valid & mem_resp_valid;

  always_comb begin
    cpl_dw           = '0;
    cpl_dw[0][31:29] = tlp_pkg::CPL_FMT_DATA;
    cpl_dw[0][28:24] = tlp_pkg::CPL_TYPE;
    cpl_dw[0][9:0]   = 10'd1;  // One dword
    cpl_dw[1][31:16] = my_id;
    cpl_dw[1][15:13] = tlp_pkg::CPL_STATUS_OK;
    cpl_dw[1][11:0]  = 12'd4;
    cpl_dw[2][31:16] = resp_req_id;
    cpl_dw[2][15:8]  = resp_tag;
    cpl_dw[2][6:0]   = resp_lower_addr;
    // 8-byte aligned address pads the header by one dword
    if (!resp_lower_addr[2])
      cpl_dw[4] = resp_rddata;
    else
      cpl_dw[3] = resp_rddata;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cpl_valid <= 1'b0;
      cpl_sop   <= 1'b0;
      cpl_eop   <= 1'b0;
    end else begin
      cpl_valid <= fire;
      cpl_sop   <= fire;
      cpl_eop   <= fire;
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      cpl_data  <= cpl_dw;
      cpl_empty <= resp_lower_addr[2] ? 3'd4 : 3'd3;
    end
  end

  assign cpld_event = cpl_valid;

endmodule

// File: rtl/tlp_stats.sv
`timescale 1ns/1ns

module tlp_stats (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           rx_event,
  input  logic                           ur_event,
  input  logic                           memreq_event,
  input  logic                           cpld_event,
  input  logic [tlp_pkg::REQ_ID_W-1:0]   my_id,
  input  logic                           csr_read,
  input  logic [tlp_pkg::CSR_ADDR_W-1:0] csr_address,
  output logic [31:0]                    csr_readdata
);

  logic [3:0]  events;
  logic [31:0] count [4];  // rx, UR, CplD, memreq

  assign events = {memreq_event, cpld_event, ur_event, rx_event};

  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (reset)
        count[i] <= '0;
      else if (events[i])
        count[i] <= count[i] + 32'd1;
    end
  end

  // Read value holds between reads
  always_ff @(posedge clk) begin
    if (csr_read) begin
      case (csr_address)
        tlp_pkg::CSR_MY_ID:        csr_readdata <= {{(32-tlp_pkg::REQ_ID_W){1'b0}}, my_id};
        tlp_pkg::CSR_RX_COUNT:     csr_readdata <= count[0];
        tlp_pkg::CSR_UR_COUNT:     csr_readdata <= count[1];
        tlp_pkg::CSR_CPLD_COUNT:   csr_readdata <= count[2];
        tlp_pkg::CSR_MEMREQ_COUNT: csr_readdata <= count[3];
        default:                   csr_readdata <= tlp_pkg::CSR_BAD_DATA;
      endcase
    end
  end

endmodule

// File: rtl/pcie_tlp_handler.sv
`timescale 1ns/1ns

module pcie_tlp_handler (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [tlp_pkg::REQ_ID_W-1:0]   my_id,
  input  logic                           my_id_valid,
  // Receive stream
  input  logic [tlp_pkg::ST_DATA_W-1:0]  rx_data,
  input  logic                           rx_sop,
  input  logic                           rx_eop,
  input  logic                           rx_valid,
  output logic                           rx_ready,
  // Memory access request
  output logic [tlp_pkg::MEM_MSG_W-1:0]  mem_req_data,
  output logic                           mem_req_valid,
  // UR completions
  output logic [tlp_pkg::ST_DATA_W-1:0]  ur_data,
  output logic                           ur_valid,
  output logic                           ur_sop,
  output logic                           ur_eop,
  output logic [tlp_pkg::EMPTY_W-1:0]    ur_empty,
  output logic [6:0]                     cpl_err,
  // Memory access response and its CplD
  input  logic [tlp_pkg::MEM_MSG_W-1:0]  mem_resp_data,
  input  logic                           mem_resp_valid,
  output logic                           mem_resp_ready,
  output logic [tlp_pkg::ST_DATA_W-1:0]  cpl_data,
  output logic                           cpl_valid,
  output logic                           cpl_sop,
  output logic                           cpl_eop,
  output logic [tlp_pkg::EMPTY_W-1:0]    cpl_empty,
  // CSR port
  input  logic                           csr_read,
  input  logic [tlp_pkg::CSR_ADDR_W-1:0] csr_address,
  output logic [31:0]                    csr_readdata
);

  logic rx_event;
  logic ur_event;
  logic memreq_event;
  logic cpld_event;

  rx_frame_if frame_if ();

  tlp_rx_decoder tlp_rx_decoder_inst (
    .clk         (clk),
    .reset       (reset),
    .my_id_valid (my_id_valid),
    .rx_data     (rx_data),
    .rx_sop      (rx_sop),
    .rx_eop      (rx_eop),
    .rx_valid    (rx_valid),
    .rx_ready    (rx_ready),
    .frame       (frame_if.producer),
    .rx_event    (rx_event)
  );

  tlp_rx_dispatch tlp_rx_dispatch_inst (
    .clk           (clk),
    .reset         (reset),
    .my_id         (my_id),
    .frame         (frame_if.consumer),
    .mem_req_data  (mem_req_data),
    .mem_req_valid (mem_req_valid),
    .ur_data       (ur_data),
    .ur_valid      (ur_valid),
    .ur_sop        (ur_sop),
    .ur_eop        (ur_eop),
    .ur_empty      (ur_empty),
    .cpl_err       (cpl_err),
    .ur_event      (ur_event),
    .memreq_event  (memreq_event)
  );

  // Response path, independent of the receive side
  cpl_response_builder cpl_response_builder_inst (
    .clk            (clk),
    .reset          (reset),
    .my_id          (my_id),
    .my_id_valid    (my_id_valid),
    .mem_resp_data  (mem_resp_data),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_ready (mem_resp_ready),
    .cpl_data       (cpl_data),
    .cpl_valid      (cpl_valid),
    .cpl_sop        (cpl_sop),
    .cpl_eop        (cpl_eop),
    .cpl_empty      (cpl_empty),
    .cpld_event     (cpld_event)
  );

  tlp_stats tlp_stats_inst (
    .clk          (clk),
    .reset        (reset),
    .rx_event     (rx_event),
    .ur_event     (ur_event),
    .memreq_event (memreq_event),
    .cpld_event   (cpld_event),
    .my_id        (my_id),
    .csr_read     (csr_read),
    .csr_address  (csr_address),
    .csr_readdata (csr_readdata)
  );

endmodule

// File: tb/tlp_vectors.svh
`ifndef TLP_VECTORS_SVH
`define TLP_VECTORS_SVH

// Outcome class of one received TLP
typedef enum logic [1:0] {
  OUT_MEMREQ,  // Memory request
  OUT_UR_NP,   // UR completion plus cpl_err bit 5
  OUT_UR_P,    // cpl_err bit 4 only
  OUT_NONE
} outcome_t;

typedef struct packed {
  logic [2:0]  fmt;
  logic [4:0]  tlp_type;
  logic [9:0]  len;
  logic [3:0]  first_be;
  logic [3:0]  last_be;
  logic [15:0] req_id;
  logic [7:0]  tag;
  logic [31:0] addr;
  outcome_t    outcome;
  logic [11:0] byte_count;  // From the PCIe byte count table
} rx_vec_t;

localparam int NUM_VECTORS = 7;

rx_vec_t vec_table [NUM_VECTORS];
string   vec_name  [NUM_VECTORS];

function automatic rx_vec_t make_row(input logic [2:0] fmt, input logic [4:0] tlp_type,
                                     input logic [9:0] len, input logic [3:0] first_be,
                                     input logic [3:0] last_be, input logic [15:0] req_id,
                                     input logic [7:0] tag, input logic [31:0] addr,
                                     input outcome_t outcome, input logic [11:0] byte_count);
  rx_vec_t r;
  r.fmt        = fmt;
  r.tlp_type   = tlp_type;
  r.len        = len;
  r.first_be   = first_be;
  r.last_be    = last_be;
  r.req_id     = req_id;
  r.tag        = tag;
  r.addr       = addr;
  r.outcome    = outcome;
  r.byte_count = byte_count;
  return r;
endfunction

// Columns: fmt, type, length, first BE, last BE, requester ID, tag, address,
// outcome, byte count
task automatic load_vector_table();
  vec_name[0]  = "mwr_1dw";
  vec_table[0] = make_row(3'b010, 5'h00, 10'd1, 4'hF, 4'h0, 16'h0100, 8'h11, 32'h8123_4568,
                          OUT_MEMREQ, 12'd4);
  vec_name[1]  = "mrd_1dw";
  vec_table[1] = make_row(3'b000, 5'h00, 10'd1, 4'hF, 4'h0, 16'hABCD, 8'h22, 32'h0007_FFFC,
                          OUT_MEMREQ, 12'd4);
  vec_name[2]  = "mrd_len2";
  vec_table[2] = make_row(3'b000, 5'h00, 10'd2, 4'hF, 4'hF, 16'h1357, 8'h33, 32'h0000_1044,
                          OUT_UR_NP, 12'd8);
  vec_name[3]  = "mrd_be3";
  vec_table[3] = make_row(3'b000, 5'h00, 10'd1, 4'h3, 4'h0, 16'h2468, 8'h44, 32'h0004_2010,
                          OUT_UR_NP, 12'd2);
  vec_name[4]  = "mwr_4dw";
  vec_table[4] = make_row(3'b011, 5'h00, 10'd1, 4'hF, 4'h0, 16'h0200, 8'h55, 32'h0000_2000,
                          OUT_UR_P, 12'd4);
  vec_name[5]  = "mwr_be1";
  vec_table[5] = make_row(3'b010, 5'h00, 10'd1, 4'h1, 4'h0, 16'h0210, 8'h5A, 32'h0000_3000,
                          OUT_UR_P, 12'd1);
  vec_name[6]  = "cpl_type";
  vec_table[6] = make_row(3'b000, 5'h0A, 10'd0, 4'h0, 4'h0, 16'h0300, 8'h66, 32'h0000_0000,
                          OUT_NONE, 12'd0);
endtask

// Single-beat request TLP, dword 0 in the low bits
function automatic logic [255:0] build_rx_beat(input rx_vec_t v, input logic [31:0] data);
  logic [7:0][31:0] dw;
  dw = '0;
  dw[0][31:29] = v.fmt;
  dw[0][28:24] = v.tlp_type;
  dw[0][9:0]   = v.len;
  dw[1] = {v.req_id, v.tag, v.last_be, v.first_be};
  if (v.fmt[0]) begin
    dw[3] = v.addr;  // Upper address dword left 0
    dw[4] = data;
  end else begin
    dw[2] = v.addr;
    dw[3] = data;
  end
  return dw;
endfunction

function automatic logic [127:0] expected_mem_req(input rx_vec_t v, input logic [31:0] data);
  logic [127:0] req;
  logic [31:0]  win;
  win    = v.addr & 32'h0007_FFFF;  // 512 KiB BAR
  req    = '0;
  req[0] = v.fmt[1];  // Write flag
  if (v.fmt[1]) begin
    req[32:1] = data;
  end else begin
    req[16:1]  = v.req_id;
    req[24:17] = v.tag;
  end
  req[62:33] = win[31:2];
  return req;
endfunction

function automatic logic [255:0] expected_ur_cpl(input rx_vec_t v, input logic [15:0] id);
  logic [7:0][31:0] dw;
  dw    = '0;
  dw[0] = {3'b000, 5'b01010, 24'h0};  // Cpl, length 0
  dw[1] = {id, 3'b001, 1'b0, v.byte_count};
  dw[2] = {v.req_id, v.tag, 1'b0, v.addr[6:0]};
  return dw;
endfunction

function automatic logic [255:0] expected_cpld(input logic [15:0] id, input logic [15:0] req,
                                               input logic [7:0] tag, input logic [6:0] la,
                                               input logic [31:0] data);
  logic [7:0][31:0] dw;
  dw    = '0;
  dw[0] = {3'b010, 5'b01010, 14'h0, 10'd1};
  dw[1] = {id, 3'b000, 1'b0, 12'd4};
  dw[2] = {req, tag, 1'b0, la};
  if (la[2])
    dw[3] = data;
  else
    dw[4] = data;  // Pad dword keeps 8-byte alignment
  return dw;
endfunction

`endif

// File: tb/tb_pcie_tlp_handler.sv
`timescale 1ns/1ns

module tb_pcie_tlp_handler;

  localparam logic [15:0] MY_ID        = 16'h0A30;
  localparam int          WATCH_CYCLES = 6;  // Per-TLP wait limit

  logic         clk;
  logic         reset;
  logic [15:0]  my_id;
  logic         my_id_valid;
  logic [255:0] rx_data;
  logic         rx_sop;
  logic         rx_eop;
  logic         rx_valid;
  logic         rx_ready;
  logic [127:0] mem_req_data;
  logic         mem_req_valid;
  logic [255:0] ur_data;
  logic         ur_valid;
  logic         ur_sop;
  logic         ur_eop;
  logic [2:0]   ur_empty;
  logic [6:0]   cpl_err;
  logic [127:0] mem_resp_data;
  logic         mem_resp_valid;
  logic         mem_resp_ready;
  logic [255:0] cpl_data;
  logic         cpl_valid;
  logic         cpl_sop;
  logic         cpl_eop;
  logic [2:0]   cpl_empty;
  logic         csr_read;
  logic [5:0]   csr_address;
  logic [31:0]  csr_readdata;

  integer seed;
  int     tally_rx;
  int     tally_ur;
  int     tally_cpld;
  int     tally_memreq;

  `include "tlp_vectors.svh"

  pcie_tlp_handler pcie_tlp_handler_inst (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_on_error(input string why);
    if (why.len() > 0)
      $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_value(input string name, input string field,
                             input logic [255:0] expected, input logic [255:0] actual);
    assert (actual === expected)
    else begin
      $display("[ERROR] %s %s: expected %0h, actual %0h", name, field, expected, actual);
      stop_on_error("");
    end
  endtask

  task automatic expect_seen(input string name, input string what, input int seen);
    assert (seen > 0)
    else stop_on_error($sformatf("%s: no %s within %0d cycles", name, what, WATCH_CYCLES));
  endtask

  task automatic check_idle(input string name);
    check_value(name, "valid outputs", '0, {mem_req_valid, ur_valid, cpl_valid, cpl_err});
  endtask

  // One TLP, then a watch window counted from the accepting edge
  task automatic apply_row(input int idx, input bit accepted);
    rx_vec_t      v;
    string        name;
    outcome_t     want;
    logic [31:0]  data;
    logic [127:0] mem_word;
    logic [255:0] ur_word;
    logic [2:0]   ur_empty_seen;
    logic         ur_framing;
    int           mem_n;
    int           ur_n;
    int           np_n;
    int           p_n;
    int           other_n;
    int           cpl_n;
    int           mem_at;
    int           ur_at;
    int           np_at;
    int           p_at;
    v       = vec_table[idx];
    name    = accepted ? vec_name[idx] : {vec_name[idx], "_no_id"};
    want    = accepted ? v.outcome : OUT_NONE;  // Dropped while ID invalid
    data    = $random(seed);
    mem_n   = 0;
    ur_n    = 0;
    np_n    = 0;
    p_n     = 0;
    other_n = 0;
    cpl_n   = 0;
    mem_at  = -1;
    ur_at   = -1;
    np_at   = -1;
    p_at    = -1;
    @(posedge clk);
    #1;
    rx_data  = build_rx_beat(v, data);
    rx_sop   = 1'b1;
    rx_eop   = 1'b1;
    rx_valid = 1'b1;
    check_value(name, "rx_ready", accepted, rx_ready);
    @(posedge clk);
    #1;
    rx_valid = 1'b0;
    rx_sop   = 1'b0;
    rx_eop   = 1'b0;
    rx_data  = '0;
    for (int k = 1; k <= WATCH_CYCLES; k++) begin
      @(negedge clk);
      if (mem_req_valid) begin
        mem_n++;
        mem_at   = k;
        mem_word = mem_req_data;
      end
      if (ur_valid) begin
        ur_n++;
        ur_at         = k;
        ur_word       = ur_data;
        ur_empty_seen = ur_empty;
        ur_framing    = ur_sop & ur_eop;
      end
      if (cpl_err[5]) begin
        np_n++;
        np_at = k;
      end
      if (cpl_err[4]) begin
        p_n++;
        p_at = k;
      end
      if (cpl_err & 7'b1001111)
        other_n++;
      if (cpl_valid)
        cpl_n++;
    end
    if (accepted)
      tally_rx++;
    if (want == OUT_MEMREQ) begin
      expect_seen(name, "memory request", mem_n);
      check_value(name, "memreq latency", 2, mem_at);
      check_value(name, "mem_req_data", expected_mem_req(v, data), mem_word);
      tally_memreq++;
    end
    check_value(name, "memreq pulses", want == OUT_MEMREQ, mem_n);
    if (want == OUT_UR_NP) begin
      expect_seen(name, "UR completion", ur_n);
      check_value(name, "UR latency", 2, ur_at);
      check_value(name, "ur_data", expected_ur_cpl(v, MY_ID), ur_word);
      check_value(name, "ur_empty", 5, ur_empty_seen);
      check_value(name, "ur sop and eop", 1, ur_framing);
      expect_seen(name, "cpl_err bit 5 pulse", np_n);
      check_value(name, "cpl_err bit 5 latency", 1, np_at);
      tally_ur++;
    end
    check_value(name, "UR pulses", want == OUT_UR_NP, ur_n);
    check_value(name, "cpl_err bit 5 pulses", want == OUT_UR_NP, np_n);
    if (want == OUT_UR_P) begin
      expect_seen(name, "cpl_err bit 4 pulse", p_n);
      check_value(name, "cpl_err bit 4 latency", 1, p_at);
    end
    check_value(name, "cpl_err bit 4 pulses", want == OUT_UR_P, p_n);
    check_value(name, "other cpl_err pulses", 0, other_n);
    check_value(name, "CplD pulses", 0, cpl_n);
  endtask

  // Memory response in, CplD out one cycle later
  task automatic apply_response(input string name, input logic [6:0] la);
    logic [15:0]  req;
    logic [7:0]   tag;
    logic [31:0]  data;
    logic [127:0] resp;
    logic [255:0] cpl_word;
    logic [2:0]   cpl_empty_seen;
    logic         cpl_framing;
    int           cpl_n;
    int           cpl_at;
    int           rx_side_n;
    req       = $random(seed);
    tag       = $random(seed);
    data      = $random(seed);
    cpl_n     = 0;
    cpl_at    = -1;
    rx_side_n = 0;
    resp          = '0;
    resp[15:0]    = req;
    resp[23:16]   = tag;
    resp[28:24]   = la[6:2];
    resp[63:32]   = data;
    @(posedge clk);
    #1;
    mem_resp_data  = resp;
    mem_resp_valid = 1'b1;
    check_value(name, "mem_resp_ready", 1, mem_resp_ready);
    @(posedge clk);
    #1;
    mem_resp_valid = 1'b0;
    mem_resp_data  = '0;
    for (int k = 1; k <= WATCH_CYCLES; k++) begin
      @(negedge clk);
      if (cpl_valid) begin
        cpl_n++;
        cpl_at         = k;
        cpl_word       = cpl_data;
        cpl_empty_seen = cpl_empty;
        cpl_framing    = cpl_sop & cpl_eop;
      end
      if (mem_req_valid || ur_valid || cpl_err != 0)
        rx_side_n++;
    end
    expect_seen(name, "CplD", cpl_n);
    check_value(name, "CplD latency", 1, cpl_at);
    check_value(name, "cpl_data", expected_cpld(MY_ID, req, tag, la, data), cpl_word);
    check_value(name, "cpl_empty", la[2] ? 4 : 3, cpl_empty_seen);
    check_value(name, "cpl sop and eop", 1, cpl_framing);
    check_value(name, "CplD pulses", 1, cpl_n);
    check_value(name, "receive side pulses", 0, rx_side_n);
    tally_cpld++;
  endtask

  task automatic read_csr(input logic [5:0] addr, output logic [31:0] value);
    @(posedge clk);
    #1;
    csr_read    = 1'b1;
    csr_address = addr;
    @(posedge clk);  // Read registered here
    #1;
    csr_read = 1'b0;
    @(negedge clk);
    value = csr_readdata;
  endtask

  initial begin
    logic [31:0] rd;
    seed           = 83819;
    tally_rx       = 0;
    tally_ur       = 0;
    tally_cpld     = 0;
    tally_memreq   = 0;
    reset          = 1'b1;
    my_id          = MY_ID;
    my_id_valid    = 1'b0;
    rx_data        = '0;
    rx_sop         = 1'b0;
    rx_eop         = 1'b0;
    rx_valid       = 1'b0;
    mem_resp_data  = '0;
    mem_resp_valid = 1'b0;
    csr_read       = 1'b0;
    csr_address    = '0;
    load_vector_table();
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    // Quiet after reset, ID still invalid
    for (int k = 0; k < 4; k++) begin
      @(negedge clk);
      check_idle("after_reset");
      check_value("after_reset", "rx_ready", 0, rx_ready);
    end
    apply_row(0, 1'b0);

    @(posedge clk);
    #1;
    my_id_valid = 1'b1;
    for (int i = 0; i < NUM_VECTORS; i++)
      apply_row(i, 1'b1);

    apply_response("cpld_la_40", 7'h40);
    apply_response("cpld_la_44", 7'h44);

    // Counter readback against the tallies
    read_csr(6'd0, rd);
    check_value("csr", "my_id", {16'h0, MY_ID}, rd);
    read_csr(6'd1, rd);
    check_value("csr", "rx count", tally_rx, rd);
    read_csr(6'd2, rd);
    check_value("csr", "UR count", tally_ur, rd);
    read_csr(6'd3, rd);
    check_value("csr", "CplD count", tally_cpld, rd);
    read_csr(6'd4, rd);
    check_value("csr", "memreq count", tally_memreq, rd);
    read_csr(6'd9, rd);
    check_value("csr", "unmapped address", 32'hFFFF_FFFF, rd);
    @(posedge clk);
    #1;
    csr_address = tlp_pkg::CSR_MY_ID;  // Mapped address, but no read strobe
    repeat (3) @(negedge clk);
    check_value("csr", "held read value", 32'hFFFF_FFFF, csr_readdata);

    $display("SIMULATION PASSED");
    $finish;
  end

  // Whole-run limit
  initial begin
    #50000;
    stop_on_error("Simulation did not finish within its time limit");
  end

endmodule

// File: tb.f
+incdir+tb
rtl/tlp_pkg.sv
rtl/rx_frame_if.sv
rtl/tlp_rx_decoder.sv
rtl/tlp_rx_dispatch.sv
rtl/cpl_response_builder.sv
rtl/tlp_stats.sv
rtl/pcie_tlp_handler.sv
tb/tb_pcie_tlp_handler.sv

// File: Bender.yml
package:
  name: pcie_tlp_handler

sources:
  - rtl/tlp_pkg.sv
  - rtl/rx_frame_if.sv
  - rtl/tlp_rx_decoder.sv
  - rtl/tlp_rx_dispatch.sv
  - rtl/cpl_response_builder.sv
  - rtl/tlp_stats.sv
  - rtl/pcie_tlp_handler.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_pcie_tlp_handler.sv
